// File: Makefile
# Verilator build and run of the asg testbench

SRC := $(shell cat asg.f)

.PHONY: run clean

run: obj_dir/Vasg_tb
	@out="$$(./obj_dir/Vasg_tb)"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

obj_dir/Vasg_tb: asg.f $(SRC)
	verilator --binary --timing --assert -Wno-fatal --top-module asg_tb -f asg.f -o Vasg_tb

clean:
	rm -rf obj_dir

// File: asg.f
design/asg_ctrl_pkg.sv
design/asg_bus_pkg.sv
design/asg_table.sv
design/asg_pointer.sv
design/asg_sequencer.sv
design/asg_stream_out.sv
design/asg.sv
verification/asg_tb.sv

// File: design/asg.sv
////////////////////////////////////////////////////////////
// one signal generator channel, table to credit stream
// parameters set here reach all four blocks
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module asg #(
  parameter int unsigned                     TN  = 2,
  parameter int unsigned                     DW  = 14,
  parameter int unsigned                     CWM = 8,
  parameter int unsigned                     CWF = 8,
  parameter int unsigned                     CWL = 16,
  parameter int unsigned                     CWN = 8,
  parameter logic [asg_ctrl_pkg::CRD_W-1:0] CRD = 4'd4
)(
  input  logic                 sto,
  input  logic                 ctl_rst,
  // triggers
  input  logic [TN-1:0]        trg_in,
  input  logic [TN-1:0]        cfg_trg,
  output logic                 trg_out,
  output logic                 irq_trg,
  output logic                 irq_stp,
  // periodic configuration
  input  logic [CWM+CWF-1:0]   cfg_siz,
  input  logic [CWM+CWF-1:0]   cfg_stp,
  input  logic [CWM+CWF-1:0]   cfg_off,
  // burst configuration
  input  logic                 cfg_ben,
  input  logic                 cfg_inf,
  input  logic [CWM-1:0]       cfg_bdl,
  input  logic [CWL-1:0]       cfg_bln,
  input  logic [CWN-1:0]       cfg_bnm,
  // status
  output logic                 sts_run,
  output logic [CWL-1:0]       sts_bln,
  output logic [CWN-1:0]       sts_bnm,
  // CPU bus
  input  asg_bus_pkg::bus_op_e bus_op,
  input  logic [CWM-1:0]       bus_addr,
  input  logic [DW-1:0]        bus_wdata,
  output logic [DW-1:0]        bus_rdata,
  output logic                 bus_ack,
  // stream
  output logic [DW-1:0]        str_dat,
  output logic                 str_vld,
  output logic                 str_lst,
  input  logic                 str_crd
);

  ////////////////////////////////////////////////////////////
  // internal wires
  ////////////////////////////////////////////////////////////

  logic           adv;
  logic           ptr_load;
  logic           ptr_step;
  logic [CWM-1:0] ptr_addr;
  logic           rd_en;
  logic           smp_vld;
  logic           smp_lst;
  logic [DW-1:0]  smp_dat;

  ////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////

  // play control
  asg_sequencer #(.TN(TN), .CWM(CWM), .CWL(CWL), .CWN(CWN)) i_sequencer (
    .sto(sto), .ctl_rst(ctl_rst), .adv(adv),
    .trg_in(trg_in), .cfg_trg(cfg_trg),
    .cfg_ben(cfg_ben), .cfg_inf(cfg_inf),
    .cfg_bdl(cfg_bdl), .cfg_bln(cfg_bln), .cfg_bnm(cfg_bnm),
    .ptr_load(ptr_load), .ptr_step(ptr_step), .rd_en(rd_en),
    .smp_vld(smp_vld), .smp_lst(smp_lst),
    .trg_out(trg_out), .irq_trg(irq_trg), .irq_stp(irq_stp),
    .sts_run(sts_run), .sts_bln(sts_bln), .sts_bnm(sts_bnm)
  );

  // phase pointer
  asg_pointer #(.CWM(CWM), .CWF(CWF)) i_pointer (
    .sto(sto), .ctl_rst(ctl_rst), .adv(adv),
    .ptr_load(ptr_load), .ptr_step(ptr_step),
    .cfg_off(cfg_off), .cfg_stp(cfg_stp), .cfg_siz(cfg_siz),
    .ptr_addr(ptr_addr)
  );

  // waveform memory
  asg_table #(.DW(DW), .CWM(CWM)) i_table (
    .sto(sto), .ctl_rst(ctl_rst),
    .bus_op(bus_op), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
    .bus_rdata(bus_rdata), .bus_ack(bus_ack),
    .rd_en(rd_en), .adv(adv), .ptr_addr(ptr_addr), .smp_dat(smp_dat)
  );

  // credit stream output
  asg_stream_out #(.DW(DW), .CRD(CRD)) i_stream_out (
    .sto(sto), .ctl_rst(ctl_rst),
    .smp_dat(smp_dat), .smp_vld(smp_vld), .smp_lst(smp_lst),
    .adv(adv),
    .str_dat(str_dat), .str_vld(str_vld), .str_lst(str_lst), .str_crd(str_crd)
  );

endmodule : asg

// File: design/asg_bus_pkg.sv
////////////////////////////////////////////////////////////
// CPU bus opcodes for waveform table access
////////////////////////////////////////////////////////////

package asg_bus_pkg;

  // one opcode per cycle on the CPU side
  typedef enum logic [1:0] {
    // no access
    op_nop = 2'd0,
    // read-back of one table word
    op_rd  = 2'd1,
    // write of one table word
    op_wr  = 2'd2
  } bus_op_e;

  // 2'd3 is unused and gets no acknowledge

endpackage : asg_bus_pkg

// File: design/asg_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// control definitions for the signal generator channel
// shared by the sequencer, the stream stage and the top
////////////////////////////////////////////////////////////

package asg_ctrl_pkg;

  //////////////////////////////////////////////////////////
  // sequencer states
  //////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    // waiting for an unmasked trigger
    st_idle = 2'd0,
    // reading samples from the table
    st_data = 2'd1,
    // burst idle part, last sample repeats
    st_hold = 2'd2,
    // burst count exhausted, pipeline drains
    st_done = 2'd3
  } asg_state_e;

  // credit counter width
  // limits the initial credit parameter to 15
  localparam int unsigned CRD_W = 4;

endpackage : asg_ctrl_pkg

// File: design/asg_pointer.sv
////////////////////////////////////////////////////////////
// fixed point phase pointer into the waveform table
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module asg_pointer #(
  parameter int unsigned CWM = 8,
  parameter int unsigned CWF = 8
)(
  input  logic               sto,
  input  logic               ctl_rst,
  input  logic               adv,
  // commands from the sequencer
  input  logic               ptr_load,
  input  logic               ptr_step,
  // configuration
  input  logic [CWM+CWF-1:0] cfg_off,
  input  logic [CWM+CWF-1:0] cfg_stp,
  input  logic [CWM+CWF-1:0] cfg_siz,
  // integer part to the table
  output logic [CWM-1:0]     ptr_addr
);

  localparam int unsigned PW = CWM + CWF;

  logic [PW-1:0] ptr_cur;
  // one extra bit for carry and for the sign of the difference
  logic [PW:0]   ptr_nxt;
  logic [PW:0]   ptr_sub;

  // step by cfg_stp+1
  assign ptr_nxt = {1'b0, ptr_cur} + {1'b0, cfg_stp} + 1'b1;
  // distance past the end of the table (cfg_siz+1)
  assign ptr_sub = ptr_nxt - ({1'b0, cfg_siz} + 1'b1);

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ptr_cur <= '0;
    end else if (adv) begin
      if (ptr_load) begin
        // start or burst restart at phase offset
        ptr_cur <= cfg_off;
      end else if (ptr_step) begin
        // negative difference means no wrap yet
        ptr_cur <= ptr_sub[PW] ? ptr_nxt[PW-1:0] : ptr_sub[PW-1:0];
      end
    end
  end

  // drop the fraction
  assign ptr_addr = ptr_cur[CWF +: CWM];

endmodule : asg_pointer

// File: design/asg_sequencer.sv
////////////////////////////////////////////////////////////
// trigger handling, play FSM and burst counters
// drives pointer and table, flags beats for the stream stage
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module asg_sequencer #(
  parameter int unsigned TN  = 2,
  parameter int unsigned CWM = 8,
  parameter int unsigned CWL = 16,
  parameter int unsigned CWN = 8
)(
  input  logic           sto,
  input  logic           ctl_rst,
  input  logic           adv,
  // triggers
  input  logic [TN-1:0]  trg_in,
  input  logic [TN-1:0]  cfg_trg,
  // burst configuration
  input  logic           cfg_ben,
  input  logic           cfg_inf,
  input  logic [CWM-1:0] cfg_bdl,
  input  logic [CWL-1:0] cfg_bln,
  input  logic [CWN-1:0] cfg_bnm,
  // pointer and table control
  output logic           ptr_load,
  output logic           ptr_step,
  output logic           rd_en,
  // beat flags, aligned with table read data
  output logic           smp_vld,
  output logic           smp_lst,
  // events and status
  output logic           trg_out,
  output logic           irq_trg,
  output logic           irq_stp,
  output logic           sts_run,
  output logic [CWL-1:0] sts_bln,
  output logic [CWN-1:0] sts_bnm
);

  asg_ctrl_pkg::asg_state_e state;

  logic trg;
  logic trg_acc;
  logic beat;
  logic end_bdl;
  logic end_bln;
  logic end_bnm;
  logic prd_end;
  logic fin;
  logic rpt;

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  // masked trigger OR
  assign trg     = |(trg_in & cfg_trg);
  // only taken in idle, ignored while running
  assign trg_acc = (state == asg_ctrl_pkg::st_idle) && trg;

  // one beat per advancing cycle in data and hold
  assign beat = (state == asg_ctrl_pkg::st_data) || (state == asg_ctrl_pkg::st_hold);

  // counter end conditions
  assign end_bdl = (sts_bln == CWL'(cfg_bdl));
  assign end_bln = (sts_bln == cfg_bln);
  // never true in infinite mode
  assign end_bnm = (sts_bnm == cfg_bnm) && !cfg_inf;

  // last beat of a burst period
  assign prd_end = beat && cfg_ben && end_bln;
  // last beat of the final period
  assign fin     = prd_end && end_bnm;
  // period end with more periods to go
  assign rpt     = prd_end && !end_bnm;

  // table reads stop in hold so the last sample repeats
  assign rd_en    = (state == asg_ctrl_pkg::st_data);
  assign ptr_load = trg_acc || rpt;
  assign ptr_step = rd_en;
  assign sts_run  = (state != asg_ctrl_pkg::st_idle);

  ////////////////////////////////////////////////////////////
  // state machine and burst counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      state   <= asg_ctrl_pkg::st_idle;
      sts_bln <= '0;
      sts_bnm <= '0;
    end else if (adv) begin
      case (state)
        asg_ctrl_pkg::st_idle: begin
          if (trg) begin
            state   <= asg_ctrl_pkg::st_data;
            sts_bln <= '0;
            sts_bnm <= '0;
          end
        end
        asg_ctrl_pkg::st_data,
        asg_ctrl_pkg::st_hold: begin
          // periodic mode never leaves st_data
          if (cfg_ben) begin
            if (end_bln) begin
              if (end_bnm) begin
                state <= asg_ctrl_pkg::st_done;
              end else begin
                // next period, pointer reloads at the same time
                state   <= asg_ctrl_pkg::st_data;
                sts_bln <= '0;
                if (!cfg_inf) begin
                  sts_bnm <= sts_bnm + 1'b1;
                end
              end
            end else begin
              sts_bln <= sts_bln + 1'b1;
              // data part done
              if ((state == asg_ctrl_pkg::st_data) && end_bdl) begin
                state <= asg_ctrl_pkg::st_hold;
              end
            end
          end
        end
        asg_ctrl_pkg::st_done: begin
          // wait until the last beat left the flag stage
          if (!smp_vld) begin
            state <= asg_ctrl_pkg::st_idle;
          end
        end
        default: begin
          state <= asg_ctrl_pkg::st_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // beat flags
  ////////////////////////////////////////////////////////////

  // one stage delay to match the registered table read
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      smp_vld <= 1'b0;
      smp_lst <= 1'b0;
    end else if (adv) begin
      smp_vld <= beat;
      smp_lst <= fin;
    end
  end

  // single cycle event pulses
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      trg_out <= 1'b0;
      irq_trg <= 1'b0;
      irq_stp <= 1'b0;
    end else begin
      trg_out <= adv && trg_acc;
      irq_trg <= adv && trg_acc;
      irq_stp <= adv && fin;
    end
  end

endmodule : asg_sequencer

// File: design/asg_stream_out.sv
////////////////////////////////////////////////////////////
// output register and credit counter
// adv throttles the whole sample pipeline
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module asg_stream_out #(
  parameter int unsigned                     DW  = 14,
  parameter logic [asg_ctrl_pkg::CRD_W-1:0] CRD = 4'd4
)(
  input  logic          sto,
  input  logic          ctl_rst,
  // from table and sequencer
  input  logic [DW-1:0] smp_dat,
  input  logic          smp_vld,
  input  logic          smp_lst,
  // pipeline enable
  output logic          adv,
  // stream
  output logic [DW-1:0] str_dat,
  output logic          str_vld,
  output logic          str_lst,
  input  logic          str_crd
);

  // output register holds a beat
  logic pnd;
  logic lst_q;
  logic send;
  logic [asg_ctrl_pkg::CRD_W-1:0] crd_cnt;

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  // a pending beat goes out only with a credit in hand
  assign send = pnd && (crd_cnt != '0);

  // register empty, or emptied this cycle
  assign adv = !pnd || send;

  assign str_vld = send;
  assign str_lst = send && lst_q;

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      pnd   <= 1'b0;
      lst_q <= 1'b0;
    end else if (adv) begin
      pnd   <= smp_vld;
      lst_q <= smp_lst;
    end
  end

  // sample word
  always_ff @(posedge sto) begin
    if (adv && smp_vld) begin
      str_dat <= smp_dat;
    end
  end

  ////////////////////////////////////////////////////////////
  // credits
  ////////////////////////////////////////////////////////////

  // credits start at CRD after reset
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      crd_cnt <= CRD;
    end else begin
      case ({str_crd, send})
        2'b10:   crd_cnt <= crd_cnt + 1'b1;
        2'b01:   crd_cnt <= crd_cnt - 1'b1;
        // return and send cancel out
        default: crd_cnt <= crd_cnt;
      endcase
    end
  end

endmodule : asg_stream_out

// File: design/asg_table.sv
////////////////////////////////////////////////////////////
// waveform table RAM, CPU port plus registered stream read
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module asg_table #(
  parameter int unsigned DW  = 14,
  parameter int unsigned CWM = 8
)(
  input  logic                 sto,
  input  logic                 ctl_rst,
  // CPU side
  input  asg_bus_pkg::bus_op_e bus_op,
  input  logic [CWM-1:0]       bus_addr,
  input  logic [DW-1:0]        bus_wdata,
  output logic [DW-1:0]        bus_rdata,
  output logic                 bus_ack,
  // stream side
  input  logic                 rd_en,
  input  logic                 adv,
  input  logic [CWM-1:0]       ptr_addr,
  output logic [DW-1:0]        smp_dat
);

  // 2**CWM sample words
  logic [DW-1:0] mem [0:2**CWM-1];

  ////////////////////////////////////////////////////////////
  // CPU access
  ////////////////////////////////////////////////////////////

  // table fill
  always_ff @(posedge sto) begin
    if (bus_op == asg_bus_pkg::op_wr) begin
      mem[bus_addr] <= bus_wdata;
    end
  end

  // read-back, valid together with bus_ack
  always_ff @(posedge sto) begin
    if (bus_op == asg_bus_pkg::op_rd) begin
      bus_rdata <= mem[bus_addr];
    end
  end

  // one cycle acknowledge for reads and writes
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      bus_ack <= 1'b0;
    end else begin
      bus_ack <= (bus_op == asg_bus_pkg::op_rd) || (bus_op == asg_bus_pkg::op_wr);
    end
  end

  ////////////////////////////////////////////////////////////
  // stream read
  ////////////////////////////////////////////////////////////

  // holds the old word while rd_en is low (burst hold)
  // or while the output stage stalls
  always_ff @(posedge sto) begin
    if (rd_en && adv) begin
      smp_dat <= mem[ptr_addr];
    end
  end

endmodule : asg_table

// File: verification/asg_tb.sv
////////////////////////////////////////////////////////////
// testbench for one signal generator channel
// table access, trigger, periodic, burst and credit checks
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module asg_tb;

  localparam int DW      = 14;
  localparam int TBL_N   = 256;
  localparam int CRD     = 4;
  localparam int RST_CYC = 10;
  localparam int PER_N   = 60;
  // 3 periods of 10 beats
  localparam int BST_N   = 30;
  // summed test lengths, up to four cycles per beat, doubled plus margin
  localparam int WDOG_CYC = 2 * (6 * RST_CYC + 3 * TBL_N + 4 * PER_N + 4 * BST_N
                                 + 4 * (CRD + 40) + 160) + 500;

  logic                 sto = 1'b0;
  logic                 ctl_rst;
  logic [1:0]           trg_in;
  logic [1:0]           cfg_trg;
  logic [15:0]          cfg_siz;
  logic [15:0]          cfg_stp;
  logic [15:0]          cfg_off;
  logic                 cfg_ben;
  logic                 cfg_inf;
  logic [7:0]           cfg_bdl;
  logic [15:0]          cfg_bln;
  logic [7:0]           cfg_bnm;
  asg_bus_pkg::bus_op_e bus_op;
  logic [7:0]           bus_addr;
  logic [DW-1:0]        bus_wdata;
  logic                 str_crd;
  logic                 trg_out;
  logic                 irq_trg;
  logic                 irq_stp;
  logic                 sts_run;
  logic [15:0]          sts_bln;
  logic [7:0]           sts_bnm;
  logic [DW-1:0]        bus_rdata;
  logic                 bus_ack;
  logic [DW-1:0]        str_dat;
  logic                 str_vld;
  logic                 str_lst;

  // model state
  int            seed = 32'hcb1e_8b34;
  logic [DW-1:0] tbl [TBL_N];
  logic [DW-1:0] exp_q [$];
  bit            lst_q [$];
  logic [DW-1:0] exp_dat;
  bit            exp_lst;
  // counters and flags
  int    beats;
  int    owed;
  int    gap;
  int    trg_cnt;
  int    stp_cnt;
  int    err_cnt;
  int    err_mark;
  int    pass_cnt;
  int    fail_cnt;
  bit    hold_crd;
  bit    run_chk;
  bit    bln_seen;
  bit    bnm_seen;
  string cur_test;

  asg i_asg (.*);

  always #50 sto = ~sto;

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////

  task automatic report_fail(input string msg);
    err_cnt++;
    $display("%s: %s", cur_test, msg);
  endtask

  task automatic report_value(input string what, input int exp_v, input int act_v);
    err_cnt++;
    $display("error %s %s: expected %0h actual %0h", cur_test, what, exp_v, act_v);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_mark = err_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == err_mark) begin
      pass_cnt++;
      $display("test %s passed", cur_test);
    end else begin
      fail_cnt++;
      $display("test %s failed with %0d errors", cur_test, err_cnt - err_mark);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // protocol checks
  ////////////////////////////////////////////////////////////

  // ack exactly one cycle after each access, never otherwise
  a_ack: assert property (@(posedge sto) disable iff (ctl_rst)
    (bus_op == asg_bus_pkg::op_rd || bus_op == asg_bus_pkg::op_wr) |=> bus_ack)
    else report_fail("bus_ack missing one cycle after an access");
  a_ack_src: assert property (@(posedge sto) disable iff (ctl_rst)
    bus_ack |-> $past(bus_op == asg_bus_pkg::op_rd || bus_op == asg_bus_pkg::op_wr))
    else report_fail("bus_ack without a preceding access");

  // trigger events follow an accepted trigger by one cycle
  a_trg: assert property (@(posedge sto) disable iff (ctl_rst)
    (!sts_run && |(trg_in & cfg_trg)) |=> (trg_out && irq_trg))
    else report_fail("trg_out or irq_trg missing after an accepted trigger");
  a_trg_src: assert property (@(posedge sto) disable iff (ctl_rst)
    (trg_out || irq_trg) |-> $past(!sts_run && |(trg_in & cfg_trg)))
    else report_fail("trigger event without an accepted trigger");

  a_lst: assert property (@(posedge sto) disable iff (ctl_rst) str_lst |-> str_vld)
    else report_fail("str_lst without str_vld");

  ////////////////////////////////////////////////////////////
  // model
  ////////////////////////////////////////////////////////////

  // step by stp+1, wrap at siz+1
  function automatic logic [15:0] next_ptr(input logic [15:0] p);
    int sum;
    sum = int'(p) + int'(cfg_stp) + 1;
    if (sum >= int'(cfg_siz) + 1) begin
      sum = sum - (int'(cfg_siz) + 1);
    end
    return 16'(sum);
  endfunction

  // expected beats, upper byte of the pointer is the table index
  task automatic build_expected(input int n, input bit burst);
    logic [15:0]   p;
    logic [DW-1:0] v;
    int            i;
    int            per;
    int            b;
    v = '0;
    p = cfg_off;
    if (!burst) begin
      for (i = 0; i < n; i++) begin
        exp_q.push_back(tbl[p[15:8]]);
        lst_q.push_back(1'b0);
        p = next_ptr(p);
      end
    end else begin
      for (per = 0; per <= int'(cfg_bnm); per++) begin
        p = cfg_off;
        for (b = 0; b <= int'(cfg_bln); b++) begin
          // data part reads, hold part repeats
          if (b <= int'(cfg_bdl)) begin
            v = tbl[p[15:8]];
            p = next_ptr(p);
          end
          exp_q.push_back(v);
          lst_q.push_back(per == int'(cfg_bnm) && b == int'(cfg_bln));
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // monitors and credit return
  ////////////////////////////////////////////////////////////

  // beat compare against the model queue
  always @(negedge sto) begin
    if (!ctl_rst && str_vld) begin
      beats++;
      owed++;
      if (exp_q.size() == 0) begin
        report_fail("stream beat beyond the model sequence");
      end else begin
        exp_dat = exp_q.pop_front();
        exp_lst = lst_q.pop_front();
        assert (str_dat == exp_dat) else report_value("str_dat", exp_dat, str_dat);
        assert (str_lst == exp_lst) else report_value("str_lst", exp_lst, str_lst);
      end
    end
  end

  // event counts, run status
  always @(negedge sto) begin
    if (!ctl_rst) begin
      if (trg_out) begin
        trg_cnt++;
      end
      if (irq_stp) begin
        stp_cnt++;
      end
      if (run_chk) begin
        assert (sts_run) else report_fail("sts_run dropped during periodic playback");
      end
      // burst counters reach the configured length and count
      if (sts_run && sts_bln == cfg_bln) begin
        bln_seen = 1'b1;
      end
      if (sts_run && sts_bnm == cfg_bnm) begin
        bnm_seen = 1'b1;
      end
    end
  end

  // one credit per beat, 0 to 3 cycles apart
  always @(posedge sto) begin
    if (ctl_rst) begin
      owed = 0;
      gap = 0;
      str_crd <= 1'b0;
    end else if (!hold_crd && owed > 0 && gap == 0) begin
      str_crd <= 1'b1;
      owed = owed - 1;
      gap = $random(seed) & 3;
    end else begin
      str_crd <= 1'b0;
      if (gap > 0) begin
        gap = gap - 1;
      end
    end
  end

  // watchdog
  initial begin
    #(WDOG_CYC * 100);
    $display("timeout: run did not finish within %0d cycles", WDOG_CYC);
    $display("Test FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic check_quiet();
    assert (!str_vld && !str_lst && !bus_ack && !trg_out && !irq_trg && !irq_stp
            && !sts_run && sts_bln == '0 && sts_bnm == '0)
      else report_fail("outputs not idle during or after reset");
  endtask

  task automatic apply_reset();
    int i;
    @(posedge sto);
    ctl_rst <= 1'b1;
    for (i = 0; i < RST_CYC - 1; i++) begin
      @(posedge sto);
      @(negedge sto);
      check_quiet();
    end
    exp_q.delete();
    lst_q.delete();
    beats = 0;
    trg_cnt = 0;
    stp_cnt = 0;
    bln_seen = 1'b0;
    bnm_seen = 1'b0;
    @(posedge sto);
    ctl_rst <= 1'b0;
  endtask

  task automatic configure(input logic ben, input logic [15:0] siz, input logic [15:0] stp,
                           input logic [15:0] off, input logic [7:0] bdl,
                           input logic [15:0] bln, input logic [7:0] bnm);
    @(posedge sto);
    cfg_ben <= ben;
    cfg_siz <= siz;
    cfg_stp <= stp;
    cfg_off <= off;
    cfg_bdl <= bdl;
    cfg_bln <= bln;
    cfg_bnm <= bnm;
    @(negedge sto);
  endtask

  task automatic bus_read(input logic [7:0] a, output logic [DW-1:0] d);
    int w;
    @(posedge sto);
    bus_op <= asg_bus_pkg::op_rd;
    bus_addr <= a;
    @(posedge sto);
    bus_op <= asg_bus_pkg::op_nop;
    @(negedge sto);
    w = 0;
    while (!bus_ack && w < 4) begin
      @(negedge sto);
      w++;
    end
    assert (bus_ack) else report_fail("no bus_ack on a table read");
    d = bus_rdata;
  endtask

  // random words, back to back writes, then full read-back
  task automatic fill_table();
    int            i;
    logic [DW-1:0] d;
    for (i = 0; i < TBL_N; i++) begin
      tbl[i] = DW'($random(seed));
    end
    for (i = 0; i < TBL_N; i++) begin
      @(posedge sto);
      bus_op <= asg_bus_pkg::op_wr;
      bus_addr <= 8'(i);
      bus_wdata <= tbl[i];
    end
    @(posedge sto);
    bus_op <= asg_bus_pkg::op_nop;
    for (i = 0; i < TBL_N; i++) begin
      bus_read(8'(i), d);
      assert (d == tbl[i]) else report_value("read-back", tbl[i], d);
    end
  endtask

  // one cycle trigger pulse, event expected or not
  task automatic pulse_trigger(input logic [1:0] v, input logic evt);
    @(posedge sto);
    trg_in <= v;
    @(posedge sto);
    trg_in <= '0;
    @(negedge sto);
    assert (trg_out == evt && irq_trg == evt)
      else report_value("trigger event", {evt, evt}, {trg_out, irq_trg});
    @(negedge sto);
    assert (!trg_out && !irq_trg) else report_fail("trigger event longer than one cycle");
  endtask

  task automatic wait_beats(input int n);
    int w;
    w = 0;
    while (beats < n && w < 8 * n + 50) begin
      @(negedge sto);
      w++;
    end
    assert (beats >= n) else report_fail("timeout waiting for stream beats");
  endtask

  task automatic wait_idle();
    int w;
    w = 0;
    while (sts_run && w < 20) begin
      @(negedge sto);
      w++;
    end
    assert (!sts_run) else report_fail("sts_run still high after the final burst");
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    ctl_rst = 1'b1;
    trg_in = '0;
    cfg_trg = 2'b01;
    cfg_siz = '0;
    cfg_stp = '0;
    cfg_off = '0;
    cfg_ben = 1'b0;
    cfg_inf = 1'b0;
    cfg_bdl = '0;
    cfg_bln = '0;
    cfg_bnm = '0;
    bus_op = asg_bus_pkg::op_nop;
    bus_addr = '0;
    bus_wdata = '0;
    str_crd = 1'b0;
    hold_crd = 1'b0;
    run_chk = 1'b0;

    start_test("reset");
    apply_reset();
    repeat (5) begin
      @(negedge sto);
      check_quiet();
    end
    end_test();

    start_test("table");
    fill_table();
    end_test();

    // 32 entry wrap, 2.5 entry step
    start_test("trigger");
    configure(1'b0, 16'h1fff, 16'h0280, 16'h0540, 8'd0, 16'd0, 8'd0);
    build_expected(120, 1'b0);
    pulse_trigger(2'b10, 1'b0);
    repeat (10) @(negedge sto);
    assert (!sts_run && beats == 0) else report_fail("masked trigger started playback");
    pulse_trigger(2'b01, 1'b1);
    end_test();

    // keeps running from the trigger test
    start_test("periodic");
    run_chk = 1'b1;
    wait_beats(PER_N / 2);
    pulse_trigger(2'b11, 1'b0);
    wait_beats(PER_N);
    run_chk = 1'b0;
    assert (trg_cnt == 1) else report_value("trigger events", 1, trg_cnt);
    end_test();

    // 5 data of 10 beats, 3 periods
    start_test("burst");
    apply_reset();
    configure(1'b1, 16'h1fff, 16'h017f, 16'h0300, 8'd4, 16'd9, 8'd2);
    build_expected(0, 1'b1);
    pulse_trigger(2'b01, 1'b1);
    wait_beats(BST_N);
    wait_idle();
    repeat (10) @(negedge sto);
    assert (beats == BST_N) else report_value("burst beats", BST_N, beats);
    assert (stp_cnt == 1) else report_value("irq_stp pulses", 1, stp_cnt);
    assert (bln_seen && bnm_seen)
      else report_fail("sts_bln or sts_bnm never reached the burst length or count");
    end_test();

    start_test("credit");
    hold_crd = 1'b1;
    apply_reset();
    configure(1'b0, 16'h1fff, 16'h0280, 16'h0540, 8'd0, 16'd0, 8'd0);
    build_expected(120, 1'b0);
    pulse_trigger(2'b01, 1'b1);
    repeat (30) @(negedge sto);
    assert (beats == CRD) else report_value("beats without credit", CRD, beats);
    hold_crd = 1'b0;
    wait_beats(CRD + 40);
    end_test();

    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : asg_tb
